//--- src.f
logic/core_pkg.sv
logic/ctrl_regs.sv
logic/rom_loader.sv
logic/shared_ram.sv
logic/osd_overlay.sv
logic/osd_sys_top.sv
test/tb_osd_sys.sv

//--- run.sh
#!/bin/sh
# Build and run the OSD system testbench with Verilator.
# Exits nonzero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_osd_sys -f src.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_osd_sys > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- test/tb_osd_sys.sv
/*
  Testbench for the OSD system top. Plays the CPU on the bus, drives
  a video raster and checks registers, scratch RAM, loader writes,
  unmapped accesses and the OSD overlay against a reference model.
*/
`timescale 1ns/1ps

module tb_osd_sys;
  import core_pkg::*;

  localparam int LINE_DE      = 260;
  localparam int LINE_HS      = 6;
  localparam int FRAME_LINES  = 70;
  localparam int FRAME_CYCLES = LINE_HS + FRAME_LINES * (LINE_DE + LINE_HS);
  // three frames, then about 620 bus transfers at up to 8 cycles each
  localparam int TIMEOUT_CYCLES = 3 * (FRAME_CYCLES + 3) + 620 * 8 + 16;

  logic                  clk;
  logic                  rst;
  cpu_req_t              i_cpu;
  logic                  o_cpu_ready;
  logic [DATA_W-1:0]     o_cpu_rdata;
  vid_sync_t             i_vid;
  logic [RGB_W-1:0]      i_c64_rgb;
  vid_sync_t             o_vid;
  logic [RGB_W-1:0]      o_rgb;
  logic [C64_CTRL_W-1:0] o_c64_ctrl;
  logic [KBD_MASK_W-1:0] o_keyboard_mask;
  load_wr_t              o_load;

  integer           seed;
  int               cycle_count;
  string            test_name;
  string            video_test;
  logic             video_busy;
  logic [31:0]      ram_model [2**RAM_WORDS_AW];
  logic [31:0]      reg_model [4];
  vid_sync_t        hist_vid [2];
  logic [RGB_W-1:0] hist_rgb [2];
  logic [1:0]       hist_ok;

  osd_sys_top dut (
    .clk             (clk),
    .rst             (rst),
    .i_cpu           (i_cpu),
    .o_cpu_ready     (o_cpu_ready),
    .o_cpu_rdata     (o_cpu_rdata),
    .i_vid           (i_vid),
    .i_c64_rgb       (i_c64_rgb),
    .o_vid           (o_vid),
    .o_rgb           (o_rgb),
    .o_c64_ctrl      (o_c64_ctrl),
    .o_keyboard_mask (o_keyboard_mask),
    .o_load          (o_load)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////////////////////////
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      stop_with_failure($sformatf("ERROR %s: expected %0h, actual %0h",
                                  name, expected, actual));
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    stop_with_failure($sformatf("timeout: tests did not finish in %0d cycles",
                                TIMEOUT_CYCLES));
  end

  // a load write may only appear together with ready
  always @(negedge clk) begin
    if (!rst) begin
      assert (!(o_load.we && !o_cpu_ready)) else begin
        stop_with_failure("load write strobe seen outside the bus ready cycle");
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // cpu bus
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] reg_addr(input int i);
    reg_addr = {REGION_REG, 20'd0, 8'(i * 4)};
  endfunction

  function automatic logic [31:0] ram_addr(input int w);
    ram_addr = {REGION_RAM, 16'd0, 10'(w), 2'b00};
  endfunction

  // 0 osd ctrl, 1 and 2 keyboard mask, 3 emulator ctrl
  function automatic logic [31:0] reg_mask(input int i);
    case (i)
      0:       reg_mask = (32'd1 << OSD_CTRL_W) - 32'd1;
      3:       reg_mask = (32'd1 << C64_CTRL_W) - 32'd1;
      default: reg_mask = 32'hffff_ffff;
    endcase
  endfunction

  task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, output logic [31:0] rdata,
                          output load_wr_t load);
    logic [31:0] r;
    r = $random(seed);
    // random idle gap
    repeat (r[1:0]) @(negedge clk);
    @(negedge clk);
    i_cpu = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    do begin
      @(negedge clk);
    end while (o_cpu_ready !== 1'b1);
    rdata = o_cpu_rdata;
    load  = o_load;
    @(negedge clk);
    i_cpu.valid = 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb);
    logic [31:0] rdata;
    load_wr_t    load;
    bus_xfer(addr, wdata, wstrb, rdata, load);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    load_wr_t load;
    bus_xfer(addr, 32'd0, 4'd0, rdata, load);
  endtask

  task automatic reg_write(input int i, input logic [31:0] wdata,
                           input logic [3:0] wstrb);
    bus_write(reg_addr(i), wdata, wstrb);
    if (wstrb == 4'hf) begin
      reg_model[i] = wdata & reg_mask(i);
    end
  endtask

  task automatic ram_write(input int w, input logic [31:0] wdata,
                           input logic [3:0] wstrb);
    bus_write(ram_addr(w), wdata, wstrb);
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        ram_model[w][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
  endtask

  task automatic ram_check(input int w);
    logic [31:0] rdata;
    bus_read(ram_addr(w), rdata);
    check_value(test_name, 64'(ram_model[w]), 64'(rdata));
  endtask

  // keeps the cpu on the ram port while a frame runs
  task automatic stalled_reads();
    logic [31:0] r;
    while (video_busy) begin
      r = $random(seed);
      ram_check(int'(r[8:0]));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // video raster and pixel model
  //////////////////////////////////////////////////////////////////////
  task automatic video_step(input logic hs, input logic vs, input logic de,
                            input int x, input int y);
    logic [10:0]      baddr;
    logic [31:0]      word;
    logic [7:0]       glyph;
    logic [1:0]       osd;
    logic             win;
    logic [RGB_W-1:0] rgb;
    logic [RGB_W-1:0] want;
    @(negedge clk);
    // outputs now show the inputs of two cycles back
    if (hist_ok[1]) begin
      check_value(video_test, 64'(hist_vid[1]), 64'(o_vid));
      check_value(video_test, 64'(hist_rgb[1]), 64'(o_rgb));
    end
    rgb   = {x[7:0], y[7:0], x[7:0] ^ y[7:0]};
    osd   = reg_model[0][1:0];
    win   = osd[0] && de && (x < 256) && (osd[1] ? (y < 8) : (y < 64));
    baddr = {y[5:0], x[7:3]};
    word  = ram_model[baddr[10:2]];
    glyph = word[baddr[1:0]*8 +: 8];
    if (!de) begin
      want = '0;
    end else if (win) begin
      want = glyph[7 - (x % 8)] ? OSD_FG_RGB : OSD_BG_RGB;
    end else begin
      want = rgb;
    end
    hist_vid[1] = hist_vid[0];
    hist_rgb[1] = hist_rgb[0];
    hist_ok     = {hist_ok[0], 1'b1};
    hist_vid[0] = '{hs: hs, vs: vs, de: de};
    hist_rgb[0] = want;
    i_vid       = hist_vid[0];
    i_c64_rgb   = rgb;
  endtask

  task automatic run_frame();
    hist_ok = 2'b00;
    for (int c = 0; c < LINE_HS; c++) begin
      video_step(1'b1, 1'b1, 1'b0, 0, 0);
    end
    for (int line = 0; line < FRAME_LINES; line++) begin
      for (int p = 0; p < LINE_DE; p++) begin
        video_step(1'b0, 1'b0, 1'b1, p, line);
      end
      for (int c = 0; c < LINE_HS; c++) begin
        video_step(1'b1, 1'b0, 1'b0, 0, line);
      end
    end
    // drain the two-cycle pipe
    repeat (3) video_step(1'b0, 1'b0, 1'b0, 0, 0);
    video_busy = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] r;
    logic [31:0] rdata;
    logic [31:0] addr;
    logic [3:0]  strb;
    load_wr_t    load;
    seed       = 32'hc7a4_3b27;
    rst        = 1'b1;
    i_cpu      = '0;
    i_vid      = '0;
    i_c64_rgb  = '0;
    video_busy = 1'b0;
    hist_ok    = 2'b00;
    video_test = "video";
    for (int i = 0; i < 4; i++) begin
      reg_model[i] = 32'd0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;

    test_name = "reset";
    check_value(test_name, 64'd0, 64'(o_cpu_ready));
    check_value(test_name, 64'd0, 64'(o_load.we));
    check_value(test_name, 64'd0, 64'(o_c64_ctrl));
    check_value(test_name, 64'd0, o_keyboard_mask);

    test_name = "registers";
    for (int i = 0; i < 4; i++) begin
      bus_read(reg_addr(i), rdata);
      check_value(test_name, 64'd0, 64'(rdata));
    end
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      reg_write(i, r, 4'hf);
    end
    for (int i = 0; i < 4; i++) begin
      bus_read(reg_addr(i), rdata);
      check_value(test_name, 64'(reg_model[i]), 64'(rdata));
    end
    check_value(test_name, 64'(reg_model[3]), 64'(o_c64_ctrl));
    check_value(test_name, {reg_model[2], reg_model[1]}, o_keyboard_mask);
    // partial strobes are ignored
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      reg_write(i, r, 4'b0111);
      bus_read(reg_addr(i), rdata);
      check_value(test_name, 64'(reg_model[i]), 64'(rdata));
    end
    reg_write(0, 32'd0, 4'hf);

    test_name = "scratch ram";
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      ram_write(512 + i * 29, r, 4'hf);
    end
    for (int i = 0; i < 16; i++) begin
      r    = $random(seed);
      strb = r[3:0];
      if (strb == 4'h0) begin
        strb = 4'h5;
      end
      r = $random(seed);
      ram_write(512 + i * 29, r, strb);
    end
    for (int i = 0; i < 16; i++) begin
      ram_check(512 + i * 29);
    end

    test_name = "loader";
    for (int t = 0; t < 6; t++) begin
      for (int lane = 0; lane < 4; lane++) begin
        r    = $random(seed);
        addr = (t < 5) ? {8'h50, 8'(t), r[15:0]} : {8'h51, r[23:0]};
        r    = $random(seed);
        strb = 4'b0001 << lane;
        bus_xfer(addr, r, strb, rdata, load);
        check_value(test_name, 64'd1, 64'(load.we));
        check_value(test_name, 64'(t), 64'(load.target));
        check_value(test_name, 64'({addr[23:2], 2'(lane)}), 64'(load.addr));
        check_value(test_name, 64'(r[lane*8 +: 8]), 64'(load.data));
      end
    end
    // two-hot strobe, then an unknown target
    bus_xfer(32'h5002_0010, r, 4'b0110, rdata, load);
    check_value(test_name, 64'd0, 64'(load.we));
    bus_xfer(32'h5007_0010, r, 4'b0001, rdata, load);
    check_value(test_name, 64'd0, 64'(load.we));

    test_name = "unmapped";
    bus_read(32'h0000_0040, rdata);
    check_value(test_name, 64'd0, 64'(rdata));
    bus_read(32'h7000_1000, rdata);
    check_value(test_name, 64'd0, 64'(rdata));
    bus_write(32'h9000_0000, 32'hdead_beef, 4'hf);
    bus_read(32'h9000_0000, rdata);
    check_value(test_name, 64'd0, 64'(rdata));

    video_test = "video passthrough";
    video_busy = 1'b1;
    run_frame();

    test_name = "osd fill";
    for (int w = 0; w < 512; w++) begin
      r = $random(seed);
      ram_write(w, r, 4'hf);
    end
    test_name = "osd stalled read";
    for (int m = 1; m <= 3; m += 2) begin
      reg_write(0, 32'(m), 4'hf);
      video_test = (m == 1) ? "osd full window" : "osd short window";
      video_busy = 1'b1;
      fork
        run_frame();
        stalled_reads();
      join
    end
    reg_write(0, 32'd0, 4'hf);

    $display("** PASS **");
    $finish;
  end

endmodule

//--- logic/osd_sys_top.sv
/*
  OSD system top: decodes the CPU bus into scratch RAM, control
  registers and loader, builds the one-cycle ready and the read
  data, and overlays the OSD on the emulated video.
*/
`timescale 1ns/1ps

module osd_sys_top (
  input  logic                            clk,
  input  logic                            rst,
  input  core_pkg::cpu_req_t              i_cpu,
  output logic                            o_cpu_ready,
  output logic [core_pkg::DATA_W-1:0]     o_cpu_rdata,
  input  core_pkg::vid_sync_t             i_vid,
  input  logic [core_pkg::RGB_W-1:0]      i_c64_rgb,
  output core_pkg::vid_sync_t             o_vid,
  output logic [core_pkg::RGB_W-1:0]      o_rgb,
  output logic [core_pkg::C64_CTRL_W-1:0] o_c64_ctrl,
  output logic [core_pkg::KBD_MASK_W-1:0] o_keyboard_mask,
  output core_pkg::load_wr_t              o_load
);
  import core_pkg::*;

  logic [3:0]            region;
  logic                  live;
  logic                  served_q;
  logic                  ready_q;
  logic                  ack;
  logic                  sel_ram;
  logic                  sel_reg;
  logic                  sel_load;
  logic                  sel_none;
  logic                  ram_grant;
  logic [DATA_W-1:0]     ram_rdata;
  logic [DATA_W-1:0]     reg_rdata;
  logic [OSD_CTRL_W-1:0] osd_ctrl;
  logic                  osd_fetch;
  logic [10:0]           osd_addr;

  //////////////////////////////////////////////////////////////////////
  // decode and handshake
  //////////////////////////////////////////////////////////////////////
  assign region = i_cpu.addr[ADDR_W-1 -: 4];

  // request not yet answered
  assign live = i_cpu.valid && !served_q;

  assign sel_ram  = live && (region == REGION_RAM);
  assign sel_reg  = live && (region == REGION_REG);
  assign sel_load = live && (region == REGION_LOAD);
  assign sel_none = live && (region != REGION_RAM) && (region != REGION_REG) &&
                    (region != REGION_LOAD);

  // ram answers only once granted
  assign ack = ram_grant || sel_reg || sel_load || sel_none;

  // served_q covers the ready cycle and any hold of valid after it
  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q  <= 1'b0;
      served_q <= 1'b0;
    end else begin
      ready_q  <= ack;
      served_q <= i_cpu.valid && (served_q || ack);
    end
  end

  assign o_cpu_ready = ready_q;

  // unmapped and loader reads give zero
  always_comb begin
    case (region)
      REGION_RAM: o_cpu_rdata = ram_rdata;
      REGION_REG: o_cpu_rdata = reg_rdata;
      default:    o_cpu_rdata = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////////////////////////
  ctrl_regs u_regs (
    .clk             (clk),
    .rst             (rst),
    .i_sel           (sel_reg),
    .i_cpu           (i_cpu),
    .o_rdata         (reg_rdata),
    .o_osd_ctrl      (osd_ctrl),
    .o_c64_ctrl      (o_c64_ctrl),
    .o_keyboard_mask (o_keyboard_mask)
  );

  rom_loader u_loader (
    .clk    (clk),
    .rst    (rst),
    .i_sel  (sel_load),
    .i_cpu  (i_cpu),
    .o_load (o_load)
  );

  shared_ram u_ram (
    .clk         (clk),
    .rst         (rst),
    .i_sel       (sel_ram),
    .i_cpu       (i_cpu),
    .i_osd_fetch (osd_fetch),
    .i_osd_addr  (osd_addr),
    .o_rdata     (ram_rdata),
    .o_cpu_grant (ram_grant)
  );

  osd_overlay u_osd (
    .clk          (clk),
    .rst          (rst),
    .i_vid        (i_vid),
    .i_c64_rgb    (i_c64_rgb),
    .i_osd_ctrl   (osd_ctrl),
    .o_fetch      (osd_fetch),
    .o_fetch_addr (osd_addr),
    .i_ram_rdata  (ram_rdata),
    .o_vid        (o_vid),
    .o_rgb        (o_rgb)
  );

endmodule

//--- logic/osd_overlay.sv
/*
  On-screen display overlay. Tracks the beam, fetches one glyph byte
  per 8 pixels from the scratch RAM and shifts it out over the
  emulated picture. Sync and colour leave two cycles late.
*/
`timescale 1ns/1ps

module osd_overlay (
  input  logic                            clk,
  input  logic                            rst,
  input  core_pkg::vid_sync_t             i_vid,
  input  logic [core_pkg::RGB_W-1:0]      i_c64_rgb,
  input  logic [core_pkg::OSD_CTRL_W-1:0] i_osd_ctrl,
  output logic                            o_fetch,
  output logic [10:0]                     o_fetch_addr,
  input  logic [core_pkg::DATA_W-1:0]     i_ram_rdata,
  output core_pkg::vid_sync_t             o_vid,
  output logic [core_pkg::RGB_W-1:0]      o_rgb
);
  import core_pkg::*;

  logic [OSD_X_W-1:0] x_q;
  logic [OSD_Y_W-1:0] y_q;
  logic               win;
  logic               fetch_p;
  logic [1:0]         lane_p;
  logic [7:0]         glyph;
  logic [7:0]         shift_q;
  vid_sync_t          vid_d1;
  vid_sync_t          vid_d2;
  logic               win_d1;
  logic               win_d2;
  logic [RGB_W-1:0]   rgb_d1;
  logic [RGB_W-1:0]   rgb_d2;

  //////////////////////////////////////////////////////////////////////
  // beam counters
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      x_q <= '0;
      y_q <= '0;
    end else begin
      if (i_vid.hs) begin
        x_q <= '0;
      end else if (i_vid.de) begin
        x_q <= x_q + 1'b1;
      end
      // step once per line, only after visible pixels
      if (i_vid.vs) begin
        y_q <= '0;
      end else if (i_vid.hs && x_q != '0) begin
        y_q <= y_q + 1'b1;
      end
    end
  end

  // 256 pixels wide, 64 or 8 lines high
  assign win = i_osd_ctrl[0] && i_vid.de && (x_q < OSD_X_W'(256)) &&
               (i_osd_ctrl[1] ? (y_q < OSD_Y_W'(8)) : (y_q < OSD_Y_W'(64)));

  assign o_fetch      = win && (x_q[2:0] == 3'd0);
  assign o_fetch_addr = {y_q[5:0], x_q[7:3]};

  //////////////////////////////////////////////////////////////////////
  // glyph shifter and delay line
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_p <= 1'b0;
      vid_d1  <= '0;
      vid_d2  <= '0;
      win_d1  <= 1'b0;
      win_d2  <= 1'b0;
    end else begin
      fetch_p <= o_fetch;
      vid_d1  <= i_vid;
      vid_d2  <= vid_d1;
      win_d1  <= win;
      win_d2  <= win_d1;
    end
  end

  // ram word arrives one cycle after the fetch
  assign glyph = i_ram_rdata[lane_p*8 +: 8];

  always_ff @(posedge clk) begin
    lane_p <= o_fetch_addr[1:0];
    rgb_d1 <= i_c64_rgb;
    rgb_d2 <= rgb_d1;
    if (fetch_p) begin
      shift_q <= glyph;
    end else begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  // msb first
  always_comb begin
    if (!vid_d2.de) begin
      o_rgb = '0;
    end else if (win_d2) begin
      o_rgb = shift_q[7] ? OSD_FG_RGB : OSD_BG_RGB;
    end else begin
      o_rgb = rgb_d2;
    end
  end

  assign o_vid = vid_d2;

endmodule

//--- logic/shared_ram.sv
/*
  Scratch RAM, four byte lanes with a synchronous read. One port,
  shared by the CPU and the OSD glyph fetch; the OSD always wins.
*/
`timescale 1ns/1ps

module shared_ram (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_sel,
  input  core_pkg::cpu_req_t          i_cpu,
  input  logic                        i_osd_fetch,
  input  logic [10:0]                 i_osd_addr,
  output logic [core_pkg::DATA_W-1:0] o_rdata,
  output logic                        o_cpu_grant
);
  import core_pkg::*;

  logic [RAM_WORDS_AW-1:0] word_addr;
  logic                    cpu_acc;
  logic                    rd_en;

  // cpu only gets the port when the osd is idle
  assign cpu_acc     = i_sel && !i_osd_fetch;
  assign o_cpu_grant = cpu_acc;
  assign rd_en       = i_osd_fetch || cpu_acc;

  // osd window lives in the low 2KB
  assign word_addr = i_osd_fetch ? RAM_WORDS_AW'(i_osd_addr[10:2])
                                 : i_cpu.addr[RAM_WORDS_AW+1:2];

  //////////////////////////////////////////////////////////////////////
  // byte lanes
  //////////////////////////////////////////////////////////////////////
  for (genvar g = 0; g < STRB_W; g++) begin : g_lane
    logic [7:0] mem [2**RAM_WORDS_AW];
    logic [7:0] rd_q;

    always_ff @(posedge clk) begin
      if (cpu_acc && i_cpu.wstrb[g]) begin
        mem[word_addr] <= i_cpu.wdata[g*8 +: 8];
      end
    end

    // read word holds until the next access
    always_ff @(posedge clk) begin
      if (rst) begin
        rd_q <= '0;
      end else if (rd_en) begin
        rd_q <= mem[word_addr];
      end
    end

    assign o_rdata[g*8 +: 8] = rd_q;
  end

endmodule

//--- logic/rom_loader.sv
/*
  ROM/RAM loader: turns a byte-strobed CPU write into one
  registered byte write to the emulator memory its address selects.
*/
`timescale 1ns/1ps

module rom_loader (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_sel,
  input  core_pkg::cpu_req_t i_cpu,
  output core_pkg::load_wr_t o_load
);
  import core_pkg::*;

  load_target_t tgt;
  logic         tgt_ok;
  logic [1:0]   lane;
  logic         one_hot;
  logic         hit;
  logic         we_q;
  load_target_t tgt_q;
  logic [23:0]  addr_q;
  logic [7:0]   data_q;

  // target from the upper address half
  always_comb begin
    tgt_ok = 1'b1;
    case (i_cpu.addr[31:16])
      16'h5000: tgt = LOAD_RAM;
      16'h5001: tgt = LOAD_BASIC;
      16'h5002: tgt = LOAD_CHAR;
      16'h5003: tgt = LOAD_KERNAL;
      16'h5004: tgt = LOAD_DRIVE;
      default: begin
        // whole 0x51 page is cartridge space
        tgt    = LOAD_CART;
        tgt_ok = (i_cpu.addr[31:24] == 8'h51);
      end
    endcase
  end

  // byte lane of a one-hot strobe
  always_comb begin
    one_hot = 1'b1;
    case (i_cpu.wstrb)
      4'b0001: lane = 2'd0;
      4'b0010: lane = 2'd1;
      4'b0100: lane = 2'd2;
      4'b1000: lane = 2'd3;
      default: begin
        lane    = 2'd0;
        one_hot = 1'b0;
      end
    endcase
  end

  assign hit = i_sel && one_hot && tgt_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      we_q <= 1'b0;
    end else begin
      we_q <= hit;
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      tgt_q  <= tgt;
      addr_q <= {i_cpu.addr[23:2], lane};
      data_q <= i_cpu.wdata[lane*8 +: 8];
    end
  end

  assign o_load = '{we: we_q, target: tgt_q, addr: addr_q, data: data_q};

endmodule

//--- logic/ctrl_regs.sv
/*
  Control register block: OSD control, emulator control and the
  64-bit keyboard mask. Full-word writes only, with readback.
*/
`timescale 1ns/1ps

module ctrl_regs (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 i_sel,
  input  core_pkg::cpu_req_t                   i_cpu,
  output logic [core_pkg::DATA_W-1:0]          o_rdata,
  output logic [core_pkg::OSD_CTRL_W-1:0]      o_osd_ctrl,
  output logic [core_pkg::C64_CTRL_W-1:0]      o_c64_ctrl,
  output logic [core_pkg::KBD_MASK_W-1:0]      o_keyboard_mask
);
  import core_pkg::*;

  logic [7:0]            ofs;
  logic                  wr_full;
  logic [OSD_CTRL_W-1:0] osd_ctrl_q;
  logic [C64_CTRL_W-1:0] c64_ctrl_q;
  logic [KBD_MASK_W-1:0] kbd_mask_q;

  assign ofs = i_cpu.addr[7:0];

  // partial strobes never touch a register
  assign wr_full = i_sel && (i_cpu.wstrb == '1);

  always_ff @(posedge clk) begin
    if (rst) begin
      osd_ctrl_q <= '0;
      c64_ctrl_q <= '0;
      kbd_mask_q <= '0;
    end else if (wr_full) begin
      case (ofs)
        REG_OSD_CTRL: osd_ctrl_q <= i_cpu.wdata[OSD_CTRL_W-1:0];
        REG_KBD_LO:   kbd_mask_q[DATA_W-1:0] <= i_cpu.wdata;
        REG_KBD_HI:   kbd_mask_q[KBD_MASK_W-1:DATA_W] <= i_cpu.wdata;
        REG_C64_CTRL: c64_ctrl_q <= i_cpu.wdata[C64_CTRL_W-1:0];
        default: ;
      endcase
    end
  end

  // readback, zero-extended
  always_comb begin
    case (ofs)
      REG_OSD_CTRL: o_rdata = DATA_W'(osd_ctrl_q);
      REG_KBD_LO:   o_rdata = kbd_mask_q[DATA_W-1:0];
      REG_KBD_HI:   o_rdata = kbd_mask_q[KBD_MASK_W-1:DATA_W];
      REG_C64_CTRL: o_rdata = DATA_W'(c64_ctrl_q);
      default:      o_rdata = '0;
    endcase
  end

  assign o_osd_ctrl      = osd_ctrl_q;
  assign o_c64_ctrl      = c64_ctrl_q;
  assign o_keyboard_mask = kbd_mask_q;

endmodule

//--- logic/core_pkg.sv
/*
  Shared definitions for the OSD system block: CPU bus widths,
  region map, register offsets, OSD colours and the bus structs.
*/
package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // cpu bus
  //////////////////////////////////////////////////////////////////////
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;

  // pixel width
  localparam int RGB_W = 24;

  // region select, top address nibble
  localparam logic [3:0] REGION_RAM = 4'h1;
  localparam logic [3:0] REGION_REG = 4'h3;
  localparam logic [3:0] REGION_LOAD = 4'h5;

  // register byte offsets
  localparam logic [7:0] REG_OSD_CTRL = 8'h00;
  localparam logic [7:0] REG_KBD_LO = 8'h04;
  localparam logic [7:0] REG_KBD_HI = 8'h08;
  localparam logic [7:0] REG_C64_CTRL = 8'h0c;

  // bit 0 enable, bit 1 short window
  localparam int OSD_CTRL_W = 2;
  localparam int C64_CTRL_W = 7;
  localparam int KBD_MASK_W = 64;

  // scratch ram depth in words
  localparam int RAM_WORDS_AW = 10;

  // beam counters
  localparam int OSD_X_W = 9;
  localparam int OSD_Y_W = 9;

  localparam logic [RGB_W-1:0] OSD_FG_RGB = 24'hff_ff_ff;
  localparam logic [RGB_W-1:0] OSD_BG_RGB = 24'h30_40_50;

  //////////////////////////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } cpu_req_t;

  typedef struct packed {
    logic hs;
    logic vs;
    logic de;
  } vid_sync_t;

  // memories filled by the loader
  typedef enum logic [2:0] {
    LOAD_RAM,
    LOAD_BASIC,
    LOAD_CHAR,
    LOAD_KERNAL,
    LOAD_DRIVE,
    LOAD_CART
  } load_target_t;

  typedef struct packed {
    logic         we;
    load_target_t target;
    logic [23:0]  addr;
    logic [7:0]   data;
  } load_wr_t;

endpackage
